//--- files.f
logic/fetch_pkg.sv
logic/instr_mem.sv
logic/bimodal_predictor.sv
logic/group_scanner.sv
logic/fetch_pc.sv
logic/dec_latch.sv
logic/fetch_unit.sv
sim/fetch_checker.sv
sim/fetch_tb.sv

//--- logic/bimodal_predictor.sv
module bimodal_predictor import fetch_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [PC_W-1:0]    pc,
    input  bp_update_t         upd,
    output logic [FETCH_W-1:0] taken
);

    ////////////////////////////////////////////////////////////
    // counter table
    ////////////////////////////////////////////////////////////

    logic [1:0] ctr [2**BHT_AW];

    // commit-side index and current count
    logic [BHT_AW-1:0] upd_idx;
    logic [1:0]        upd_ctr;
    logic [1:0]        upd_next;

    assign upd_idx = upd.pc[BHT_AW-1:0];
    assign upd_ctr = ctr[upd_idx];

    // saturating step toward the committed outcome
    always_comb begin
        upd_next = upd_ctr;
        if (upd.taken) begin
            if (upd_ctr != 2'b11) begin
                upd_next = upd_ctr + 2'd1;
            end
        end else begin
            if (upd_ctr != 2'b00) begin
                upd_next = upd_ctr - 2'd1;
            end
        end
    end

    // one update per cycle, independent of stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**BHT_AW; i++) begin
                ctr[i] <= CTR_INIT;
            end
        end else if (upd.valid) begin
            ctr[upd_idx] <= upd_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    logic [BHT_AW-1:0] rd_idx [FETCH_W];

    // slot i looks up pc+i, msb of the counter is the prediction
    always_comb begin
        for (int i = 0; i < FETCH_W; i++) begin
            rd_idx[i] = pc[BHT_AW-1:0] + BHT_AW'(i);
            taken[i]  = ctr[rd_idx[i]][1];
        end
    end

endmodule

//--- logic/dec_latch.sv
module dec_latch import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         stall,
    input  logic         recover_en,
    input  logic         load_pc_en,
    input  fetch_group_t scan_group,
    output fetch_group_t dec_group
);

    logic         flush;
    logic         valid_q;
    fetch_group_t group_q;

    // either redirect from outside kills the group in flight
    assign flush = recover_en | load_pc_en;

    // valid bit cleared by reset and flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= 1'b1;
        end
    end

    // payload captured only when decode accepts
    always_ff @(posedge clk) begin
        if (!flush && !stall) begin
            group_q <= scan_group;
        end
    end

    // valid comes from the latch alone
    always_comb begin
        dec_group       = group_q;
        dec_group.valid = valid_q;
    end

endmodule

//--- logic/fetch_pc.sv
module fetch_pc import fetch_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            recover_en,
    input  logic            load_pc_en,
    input  logic [PC_W-1:0] recover_pc,
    input  logic [PC_W-1:0] load_pc,
    input  logic [PC_W-1:0] next_pc,
    output logic [PC_W-1:0] pc
);

    logic [PC_W-1:0] pc_next;

    ////////////////////////////////////////////////////////////
    // next pc priority
    ////////////////////////////////////////////////////////////

    always_comb begin
        // misprediction beats everything
        if (recover_en) begin
            pc_next = recover_pc;
        // external load
        end else if (load_pc_en) begin
            pc_next = load_pc;
        // decode full, keep position
        end else if (stall) begin
            pc_next = pc;
        // predicted continuation from the scanner
        end else begin
            pc_next = next_pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // pc register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

//--- logic/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    // program counter width
    localparam int PC_W = 16;
    // slots per fetch group
    localparam int FETCH_W = 4;
    // instruction RAM address bits, low PC bits
    localparam int IMEM_AW = 6;
    // predictor index bits
    localparam int BHT_AW = 4;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    localparam logic [3:0] OP_BRANCH = 4'hC;
    localparam logic [3:0] OP_JUMP = 4'hD;

    // weakly not taken
    localparam logic [1:0] CTR_INIT = 2'b01;

    // conditional branch layout
    typedef struct packed {
        logic [3:0]        opcode;
        logic [3:0]        rs;
        logic signed [7:0] offset;
    } branch_fmt_t;

    // immediate jump layout, target within the current 4k page
    typedef struct packed {
        logic [3:0]  opcode;
        logic [11:0] target;
    } jump_fmt_t;

    // one word, two views sharing the opcode field
    typedef union packed {
        branch_fmt_t br;
        jump_fmt_t   jmp;
    } instr_t;

    // group handed to decode
    typedef struct packed {
        logic                      valid;
        logic [PC_W-1:0]           pc;
        instr_t [FETCH_W-1:0]      instr;
        logic [FETCH_W-1:0]        slot_valid;
        logic [FETCH_W-1:0]        pred_taken;
        logic [PC_W-1:0]           next_pc;
    } fetch_group_t;

    // committed branch outcome from the ROB
    typedef struct packed {
        logic            valid;
        logic [PC_W-1:0] pc;
        logic            taken;
    } bp_update_t;

    // instruction RAM fill port
    typedef struct packed {
        logic               en;
        logic [IMEM_AW-1:0] addr;
        instr_t             data;
    } imem_write_t;

endpackage

//--- logic/fetch_unit.sv
module fetch_unit import fetch_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            recover_en,
    input  logic [PC_W-1:0] recover_pc,
    input  logic            load_pc_en,
    input  logic [PC_W-1:0] load_pc,
    input  bp_update_t      bp_update,
    input  imem_write_t     imem_wr,
    output fetch_group_t    dec_group
);

    ////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////

    logic [PC_W-1:0]      pc;
    instr_t [FETCH_W-1:0] words;
    logic [FETCH_W-1:0]   bp_taken;
    fetch_group_t         scan_group;

    // pc register and redirect priority
    fetch_pc u_fetch_pc (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .recover_en (recover_en),
        .load_pc_en (load_pc_en),
        .recover_pc (recover_pc),
        .load_pc    (load_pc),
        .next_pc    (scan_group.next_pc),
        .pc         (pc)
    );

    // four words at pc..pc+3
    instr_mem u_instr_mem (
        .clk   (clk),
        .wr    (imem_wr),
        .pc    (pc),
        .words (words)
    );

    // 2-bit counters, trained at commit
    bimodal_predictor u_bimodal_predictor (
        .clk   (clk),
        .rst_n (rst_n),
        .pc    (pc),
        .upd   (bp_update),
        .taken (bp_taken)
    );

    // decode, targets, group cut
    group_scanner u_group_scanner (
        .pc    (pc),
        .words (words),
        .taken (bp_taken),
        .group (scan_group)
    );

    // register toward decode
    dec_latch u_dec_latch (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .recover_en (recover_en),
        .load_pc_en (load_pc_en),
        .scan_group (scan_group),
        .dec_group  (dec_group)
    );

endmodule

//--- logic/group_scanner.sv
module group_scanner import fetch_pkg::*; (
    input  logic [PC_W-1:0]      pc,
    input  instr_t [FETCH_W-1:0] words,
    input  logic [FETCH_W-1:0]   taken,
    output fetch_group_t         group
);

    ////////////////////////////////////////////////////////////
    // per-slot decode
    ////////////////////////////////////////////////////////////

    logic [PC_W-1:0]    slot_pc  [FETCH_W];
    logic [PC_W-1:0]    br_tgt   [FETCH_W];
    logic [PC_W-1:0]    jmp_tgt  [FETCH_W];
    logic [FETCH_W-1:0] is_br;
    logic [FETCH_W-1:0] is_jmp;

    always_comb begin
        for (int i = 0; i < FETCH_W; i++) begin
            slot_pc[i] = pc + PC_W'(i);
            // branch view
            is_br[i]   = (words[i].br.opcode == OP_BRANCH);
            // sign-extended offset relative to the slot
            br_tgt[i]  = slot_pc[i] +
                         {{(PC_W-8){words[i].br.offset[7]}}, words[i].br.offset};
            // jump view
            is_jmp[i]  = (words[i].jmp.opcode == OP_JUMP);
            // page bits of the slot pc, low bits from the word
            jmp_tgt[i] = {slot_pc[i][PC_W-1:PC_W-4], words[i].jmp.target};
        end
    end

    ////////////////////////////////////////////////////////////
    // first redirect search
    ////////////////////////////////////////////////////////////

    logic [FETCH_W-1:0] slot_valid;
    logic [FETCH_W-1:0] pred_taken;
    logic [PC_W-1:0]    next_pc;
    logic               found;

    always_comb begin
        found      = 1'b0;
        slot_valid = '0;
        pred_taken = '0;
        // fall through when nothing redirects
        next_pc    = pc + PC_W'(FETCH_W);
        for (int i = 0; i < FETCH_W; i++) begin
            // slots past the redirect are dropped
            if (!found) begin
                slot_valid[i] = 1'b1;
                pred_taken[i] = is_br[i] & taken[i];
                if (is_jmp[i]) begin
                    found   = 1'b1;
                    next_pc = jmp_tgt[i];
                end else if (is_br[i] && taken[i]) begin
                    found   = 1'b1;
                    next_pc = br_tgt[i];
                end
            end
        end
    end

    // valid left high, qualified downstream
    always_comb begin
        group.valid      = 1'b1;
        group.pc         = pc;
        group.instr      = words;
        group.slot_valid = slot_valid;
        group.pred_taken = pred_taken;
        group.next_pc    = next_pc;
    end

endmodule

//--- logic/instr_mem.sv
module instr_mem import fetch_pkg::*; (
    input  logic                 clk,
    input  imem_write_t          wr,
    input  logic [PC_W-1:0]      pc,
    output instr_t [FETCH_W-1:0] words
);

    // storage array
    instr_t mem [2**IMEM_AW];

    // per-slot read addresses
    logic [IMEM_AW-1:0] rd_addr [FETCH_W];

    // single synchronous write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // slot i reads pc+i, wrapping inside the array
    always_comb begin
        for (int i = 0; i < FETCH_W; i++) begin
            rd_addr[i] = pc[IMEM_AW-1:0] + IMEM_AW'(i);
        end
    end

    // combinational reads, old data during a same-cycle write
    always_comb begin
        for (int i = 0; i < FETCH_W; i++) begin
            words[i] = mem[rd_addr[i]];
        end
    end

endmodule

//--- sim/fetch_checker.sv
module fetch_checker import fetch_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            recover_en,
    input  logic [PC_W-1:0] recover_pc,
    input  logic            load_pc_en,
    input  logic [PC_W-1:0] load_pc,
    input  bp_update_t      bp_update,
    input  imem_write_t     imem_wr,
    input  fetch_group_t    dec_group,
    input  logic [95:0]     test_name,
    output int              checks,
    output int              errors
);

    ////////////////////////////////////////////////////////////
    // model state
    ////////////////////////////////////////////////////////////

    logic [15:0]  mem [64];
    logic [1:0]   ctr [16];
    logic [15:0]  model_pc;
    fetch_group_t scan;
    fetch_group_t exp_grp;

    // expected group at pc p, from the group rules
    function automatic fetch_group_t expect_group(logic [15:0] p);
        fetch_group_t g;
        logic         cut;
        logic [15:0]  spc;
        logic [15:0]  w;
        g         = '0;
        g.valid   = 1'b1;
        g.pc      = p;
        g.next_pc = p + 16'd4;
        cut       = 1'b0;
        for (int i = 0; i < 4; i++) begin
            spc        = p + 16'(i);
            w          = mem[spc[5:0]];
            g.instr[i] = w;
            if (!cut) begin
                g.slot_valid[i] = 1'b1;
                // jump keeps the page of the slot
                if (w[15:12] == 4'hD) begin
                    cut       = 1'b1;
                    g.next_pc = {spc[15:12], w[11:0]};
                end else if (w[15:12] == 4'hC && ctr[spc[3:0]] >= 2'd2) begin
                    cut             = 1'b1;
                    g.pred_taken[i] = 1'b1;
                    g.next_pc       = spc + {{8{w[7]}}, w[7:0]};
                end
            end
        end
        return g;
    endfunction

    // cycle rule, model state before the edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_pc = '0;
            exp_grp  = '0;
            for (int i = 0; i < 16; i++) begin
                ctr[i] = 2'b01;
            end
        end else begin
            scan = expect_group(model_pc);
            if (recover_en) begin
                model_pc      = recover_pc;
                exp_grp.valid = 1'b0;
            end else if (load_pc_en) begin
                model_pc      = load_pc;
                exp_grp.valid = 1'b0;
            end else if (!stall) begin
                exp_grp  = scan;
                model_pc = scan.next_pc;
            end
            // side effects regardless of stall
            if (bp_update.valid) begin
                if (bp_update.taken && ctr[bp_update.pc[3:0]] != 2'd3) begin
                    ctr[bp_update.pc[3:0]] = ctr[bp_update.pc[3:0]] + 2'd1;
                end else if (!bp_update.taken && ctr[bp_update.pc[3:0]] != 2'd0) begin
                    ctr[bp_update.pc[3:0]] = ctr[bp_update.pc[3:0]] - 2'd1;
                end
            end
            if (imem_wr.en) begin
                mem[imem_wr.addr] = imem_wr.data;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // comparison, mid cycle
    ////////////////////////////////////////////////////////////

    initial begin
        checks = 0;
        errors = 0;
    end

    always @(negedge clk) begin
        if (rst_n) begin
            checks = checks + 1;
            // payload only matters while valid
            if (dec_group.valid !== exp_grp.valid) begin
                errors = errors + 1;
                $display("[ERROR] %0s: valid expected %0b actual %0b",
                         test_name, exp_grp.valid, dec_group.valid);
            end else if (exp_grp.valid && dec_group !== exp_grp) begin
                errors = errors + 1;
                $display("[ERROR] %0s: group expected %h actual %h",
                         test_name, exp_grp, dec_group);
            end
        end
    end

endmodule

//--- sim/fetch_tb.sv
module fetch_tb import fetch_pkg::*; ();

    // cycles of reset, the six sequences and the tail
    localparam int RUN_CYCLES = 16 + 77 + 13 + 26 + 13 + 13 + 465 + 4;

    logic            clk;
    logic            rst_n;
    logic            stall;
    logic            recover_en;
    logic [PC_W-1:0] recover_pc;
    logic            load_pc_en;
    logic [PC_W-1:0] load_pc;
    bp_update_t      bp_update;
    imem_write_t     imem_wr;
    fetch_group_t    dec_group;
    logic [95:0]     test_name;
    logic [31:0]     lfsr;
    int              checks;
    int              errors;

    fetch_unit dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .recover_en (recover_en),
        .recover_pc (recover_pc),
        .load_pc_en (load_pc_en),
        .load_pc    (load_pc),
        .bp_update  (bp_update),
        .imem_wr    (imem_wr),
        .dec_group  (dec_group)
    );

    fetch_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .recover_en (recover_en),
        .recover_pc (recover_pc),
        .load_pc_en (load_pc_en),
        .load_pc    (load_pc),
        .bp_update  (bp_update),
        .imem_wr    (imem_wr),
        .dec_group  (dec_group),
        .test_name  (test_name),
        .checks     (checks),
        .errors     (errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // random source
    ////////////////////////////////////////////////////////////

    // right-shift galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // about one in four is a branch or jump
    function automatic logic [15:0] random_word();
        logic [15:0] w;
        w = 16'(rand_bits(16));
        if (rand_bits(2) == 0) begin
            w[15:12] = rand_bits(1) ? OP_JUMP : OP_BRANCH;
        end else begin
            w[15:12] = {1'b0, w[14:12]};
        end
        return w;
    endfunction

    // plain opcode with the rest from the whole address
    function automatic logic [15:0] plain_word(logic [5:0] a);
        return {4'h1, 2'b10, a, ~a[3:0]};
    endfunction

    ////////////////////////////////////////////////////////////
    // drive helpers
    ////////////////////////////////////////////////////////////

    // strobes drop unless the caller sets them again
    task automatic next_cycle();
        @(posedge clk);
        stall      <= 1'b0;
        recover_en <= 1'b0;
        load_pc_en <= 1'b0;
        bp_update  <= '0;
        imem_wr    <= '0;
    endtask

    task automatic run_cycles(int n);
        repeat (n) next_cycle();
    endtask

    task automatic write_word(logic [5:0] a, logic [15:0] w);
        next_cycle();
        imem_wr <= {1'b1, a, w};
    endtask

    task automatic start_at(logic [15:0] p);
        next_cycle();
        load_pc_en <= 1'b1;
        load_pc    <= p;
    endtask

    task automatic train(logic [15:0] p, logic t, int n);
        repeat (n) begin
            next_cycle();
            bp_update <= {1'b1, p, t};
        end
    endtask

    // fetch held while the whole RAM is written
    task automatic fill_memory(logic use_random);
        for (int a = 0; a < 64; a++) begin
            next_cycle();
            stall   <= 1'b1;
            imem_wr <= {1'b1, 6'(a), use_random ? random_word() : plain_word(6'(a))};
        end
    endtask

    ////////////////////////////////////////////////////////////
    // sequences
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n      = 1'b0;
        stall      = 1'b1;
        recover_en = 1'b0;
        recover_pc = '0;
        load_pc_en = 1'b0;
        load_pc    = '0;
        bp_update  = '0;
        imem_wr    = '0;
        lfsr       = 32'h7bf5_ab69;
        test_name  = "reset";
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // sequential fetch starting near the top to wrap
        test_name = "sequential";
        fill_memory(1'b0);
        start_at(16'h003E);
        run_cycles(12);

        // two jumps forming a loop
        test_name = "jumps";
        write_word(6'h12, 16'hD020);
        write_word(6'h21, 16'hD010);
        start_at(16'h0010);
        run_cycles(10);

        // branch at 0x31 with offset +8
        test_name = "branches";
        write_word(6'h31, 16'hC108);
        start_at(16'h0030);
        run_cycles(6);
        train(16'h0031, 1'b1, 2);
        start_at(16'h0030);
        run_cycles(6);
        train(16'h0031, 1'b0, 2);
        start_at(16'h0030);
        run_cycles(6);

        test_name = "stall";
        start_at(16'h0000);
        run_cycles(3);
        repeat (5) begin
            next_cycle();
            stall <= 1'b1;
        end
        run_cycles(4);

        test_name = "redirect";
        next_cycle();
        recover_en <= 1'b1;
        recover_pc <= 16'h0008;
        run_cycles(3);
        start_at(16'h0018);
        run_cycles(3);
        // recovery wins over load
        next_cycle();
        recover_en <= 1'b1;
        recover_pc <= 16'h0028;
        load_pc_en <= 1'b1;
        load_pc    <= 16'h0004;
        run_cycles(4);

        test_name = "random";
        fill_memory(1'b1);
        start_at(16'(rand_bits(16)));
        repeat (400) begin
            next_cycle();
            stall <= (rand_bits(2) == 0);
            if (rand_bits(5) == 0) begin
                recover_en <= 1'b1;
                recover_pc <= 16'(rand_bits(16));
            end
            if (rand_bits(6) == 0) begin
                load_pc_en <= 1'b1;
                load_pc    <= 16'(rand_bits(16));
            end
            if (rand_bits(2) == 0) begin
                bp_update <= {1'b1, 16'(rand_bits(16)), 1'(rand_bits(1))};
            end
            if (rand_bits(2) == 0) begin
                imem_wr <= {1'b1, 6'(rand_bits(6)), random_word()};
            end
        end
        run_cycles(3);

        @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // run limit at twice the expected length
    initial begin
        #(2 * RUN_CYCLES * 20);
        $display("watchdog expired before the sequences finished");
        $display("test failed");
        $finish;
    end

endmodule
